// ==== decode_pkg.sv ====
package decode_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // field widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int INST_W = 32;                   // raw RV32I instruction word.
    localparam int OP_W   = 7;                    // major opcode in bits 6:0.
    localparam int F3_W   = 3;
    localparam int F7_W   = 7;
    localparam int OPC_W  = F7_W + F3_W + OP_W;   // funct7, funct3, opcode.
    localparam int REG_W  = 5;
    localparam int CSR_W  = 12;
    localparam int IMM_W  = 32;

    // the decoder puts this on imm for any encoding it does not know.
    localparam logic [IMM_W-1:0] UNIMP_IMM = '1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // RV32I major opcodes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [OP_W-1:0] {
        OP_LUI     = 7'b0110111,
        OP_AUIPC   = 7'b0010111,
        OP_JAL     = 7'b1101111,
        OP_JALR    = 7'b1100111,
        OP_BRANCH  = 7'b1100011,
        OP_LOAD    = 7'b0000011,
        OP_STORE   = 7'b0100011,
        OP_OPIMM   = 7'b0010011,
        OP_OP      = 7'b0110011,
        OP_MISCMEM = 7'b0001111,
        OP_SYSTEM  = 7'b1110011
    } opcode_e;

    // funct3 values of the two OP-IMM shift groups, which keep funct7.
    localparam logic [F3_W-1:0] F3_SLLI  = 3'b001;
    localparam logic [F3_W-1:0] F3_SRXI  = 3'b101;

endpackage

// ==== decode_if.sv ====
interface decode_if
    import decode_pkg::*;
#(
    parameter int PC_W = 32
) ();

    logic [PC_W-1:0]  pc;
    logic [OPC_W-1:0] opc;
    logic [REG_W-1:0] rd;
    logic [REG_W-1:0] rs1;
    logic [REG_W-1:0] rs2;
    logic [IMM_W-1:0] imm;
    logic [CSR_W-1:0] csr;

    modport src (
        output pc, opc, rd, rs1, rs2, imm, csr
    );

    modport dst (
        input pc, opc, rd, rs1, rs2, imm, csr
    );

endinterface

// ==== fetch_latch.sv ====
module fetch_latch
    import decode_pkg::*;
#(
    parameter int PC_W = 32
) (
    input  logic              CLK,
    input  logic              arst_n,
    input  logic              flush,
    input  logic              stall,
    input  logic              mem_wait,

    input  logic [INST_W-1:0] inst,
    input  logic [PC_W-1:0]   pc,

    output logic [INST_W-1:0] inst_q,
    output logic [PC_W-1:0]   pc_q
);

    logic hold;

    assign hold = stall || mem_wait;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fetch register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            inst_q <= '0;
            pc_q   <= '0;
        end else if (flush) begin
            inst_q <= '0;                  // a zero word decodes as unimp downstream.
            pc_q   <= '0;
        end else if (!hold) begin
            inst_q <= inst;
            pc_q   <= pc;
        end
    end

endmodule

// ==== inst_decoder.sv ====
module inst_decoder
    import decode_pkg::*;
#(
    parameter int PC_W = 32
) (
    input  logic [INST_W-1:0] inst,
    input  logic [PC_W-1:0]   pc,
    decode_if.src             dec
);

    opcode_e          op;
    logic [F3_W-1:0]  f3;
    logic [F7_W-1:0]  f7;

    logic [IMM_W-1:0] imm_i;
    logic [IMM_W-1:0] imm_s;
    logic [IMM_W-1:0] imm_b;
    logic [IMM_W-1:0] imm_u;
    logic [IMM_W-1:0] imm_j;

    logic [OP_W-1:0]  op_sel;
    logic [F3_W-1:0]  f3_sel;
    logic [F7_W-1:0]  f7_sel;
    logic [REG_W-1:0] rd_sel;
    logic [REG_W-1:0] rs1_sel;
    logic [REG_W-1:0] rs2_sel;
    logic [IMM_W-1:0] imm_sel;

    assign op = opcode_e'(inst[6:0]);
    assign f3 = inst[14:12];
    assign f7 = inst[31:25];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // immediates of every format
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        op_sel  = '0;                      // unknown words leave every field clear.
        f3_sel  = '0;
        f7_sel  = '0;
        rd_sel  = '0;
        rs1_sel = '0;
        rs2_sel = '0;
        imm_sel = UNIMP_IMM;

        case (op)
            OP_LUI, OP_AUIPC: begin
                op_sel  = op;
                rd_sel  = inst[11:7];
                imm_sel = imm_u;
            end
            OP_JAL: begin
                op_sel  = op;
                rd_sel  = inst[11:7];
                imm_sel = imm_j;
            end
            OP_JALR, OP_LOAD, OP_MISCMEM, OP_SYSTEM: begin
                op_sel  = op;
                f3_sel  = f3;
                rd_sel  = inst[11:7];
                rs1_sel = inst[19:15];
                imm_sel = imm_i;               // SYSTEM carries the CSR number here.
            end
            OP_OPIMM: begin
                op_sel  = op;
                f3_sel  = f3;
                rd_sel  = inst[11:7];
                rs1_sel = inst[19:15];
                imm_sel = imm_i;
                if (f3 == F3_SLLI || f3 == F3_SRXI) begin
                    f7_sel = f7;               // tells SRLI from SRAI.
                end
            end
            OP_BRANCH: begin
                op_sel  = op;
                f3_sel  = f3;
                rs1_sel = inst[19:15];
                rs2_sel = inst[24:20];
                imm_sel = imm_b;
            end
            OP_STORE: begin
                op_sel  = op;
                f3_sel  = f3;
                rs1_sel = inst[19:15];
                rs2_sel = inst[24:20];
                imm_sel = imm_s;
            end
            OP_OP: begin
                op_sel  = op;
                f3_sel  = f3;
                f7_sel  = f7;
                rd_sel  = inst[11:7];
                rs1_sel = inst[19:15];
                rs2_sel = inst[24:20];
                imm_sel = '0;                  // R format has no immediate.
            end
            default: ;
        endcase
    end

    assign dec.pc  = pc;
    assign dec.opc = {f7_sel, f3_sel, op_sel};
    assign dec.rd  = rd_sel;
    assign dec.rs1 = rs1_sel;
    assign dec.rs2 = rs2_sel;
    assign dec.imm = imm_sel;
    assign dec.csr = '0;                       // the check stage derives csr.

endmodule

// ==== decode_check.sv ====
module decode_check
    import decode_pkg::*;
#(
    parameter int PC_W = 32
) (
    input  logic  CLK,
    input  logic  arst_n,
    input  logic  flush,
    input  logic  stall,
    input  logic  mem_wait,
    decode_if.dst in_d,
    decode_if.src out_d
);

    logic [PC_W-1:0]  pc_q;
    logic [OPC_W-1:0] opc_q;
    logic [REG_W-1:0] rd_q;
    logic [REG_W-1:0] rs1_q;
    logic [REG_W-1:0] rs2_q;
    logic [IMM_W-1:0] imm_q;
    logic             is_unimp;

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            pc_q  <= '0;
            opc_q <= '0;
            rd_q  <= '0;
            rs1_q <= '0;
            rs2_q <= '0;
            imm_q <= '0;
        end else if (flush) begin
            pc_q  <= '0;
            opc_q <= '0;
            rd_q  <= '0;
            rs1_q <= '0;
            rs2_q <= '0;
            imm_q <= '0;
        end else if (!(stall || mem_wait)) begin
            pc_q  <= in_d.pc;
            opc_q <= in_d.opc;
            rd_q  <= in_d.rd;
            rs1_q <= in_d.rs1;
            rs2_q <= in_d.rs2;
            imm_q <= in_d.imm;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // unimp becomes a bare JAL after the register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign is_unimp = (imm_q == UNIMP_IMM);

    assign out_d.pc  = pc_q;                   // pc survives the substitution.
    assign out_d.opc = is_unimp ? {{(F7_W + F3_W){1'b0}}, OP_JAL} : opc_q;
    assign out_d.rd  = is_unimp ? '0 : rd_q;
    assign out_d.rs1 = is_unimp ? '0 : rs1_q;
    assign out_d.rs2 = is_unimp ? '0 : rs2_q;
    assign out_d.csr = is_unimp ? '0 : imm_q[CSR_W-1:0];
    assign out_d.imm = is_unimp ? '0 : imm_q;

endmodule

// ==== issue_latch.sv ====
module issue_latch
    import decode_pkg::*;
#(
    parameter int PC_W = 32
) (
    input  logic             CLK,
    input  logic             arst_n,
    input  logic             flush,
    input  logic             stall,
    input  logic             mem_wait,
    decode_if.dst            in_d,

    output logic [PC_W-1:0]  pc,
    output logic [OPC_W-1:0] opc,
    output logic [REG_W-1:0] rd,
    output logic [REG_W-1:0] rs1,
    output logic [REG_W-1:0] rs2,
    output logic [CSR_W-1:0] csr,
    output logic [IMM_W-1:0] imm
);

    logic hold;

    assign hold = stall || mem_wait;           // the scheduler sees the same word again.

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            pc  <= '0;
            opc <= '0;
            rd  <= '0;
            rs1 <= '0;
            rs2 <= '0;
            csr <= '0;
            imm <= '0;
        end else if (flush) begin
            pc  <= '0;
            opc <= '0;
            rd  <= '0;
            rs1 <= '0;
            rs2 <= '0;
            csr <= '0;
            imm <= '0;
        end else if (!hold) begin
            pc  <= in_d.pc;
            opc <= in_d.opc;
            rd  <= in_d.rd;
            rs1 <= in_d.rs1;
            rs2 <= in_d.rs2;
            csr <= in_d.csr;
            imm <= in_d.imm;
        end
    end

endmodule

// ==== decode_front.sv ====
module decode_front
    import decode_pkg::*;
#(
    parameter int PC_W = 32
) (
    input  logic              CLK,
    input  logic              arst_n,
    input  logic              flush,
    input  logic              stall,
    input  logic              mem_wait,

    input  logic [INST_W-1:0] inst,
    input  logic [PC_W-1:0]   pc,

    output logic [PC_W-1:0]   out_pc,
    output logic [OPC_W-1:0]  out_opc,
    output logic [REG_W-1:0]  out_rd,
    output logic [REG_W-1:0]  out_rs1,
    output logic [REG_W-1:0]  out_rs2,
    output logic [CSR_W-1:0]  out_csr,
    output logic [IMM_W-1:0]  out_imm
);

    logic [INST_W-1:0] inst_q;
    logic [PC_W-1:0]   pc_q;

    decode_if #(.PC_W(PC_W)) if_dec ();        // decoder to check stage.
    decode_if #(.PC_W(PC_W)) if_chk ();        // check stage to issue latch.

    fetch_latch #(.PC_W(PC_W)) i_fetch (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .flush    (flush),
        .stall    (stall),
        .mem_wait (mem_wait),
        .inst     (inst),
        .pc       (pc),
        .inst_q   (inst_q),
        .pc_q     (pc_q)
    );

    inst_decoder #(.PC_W(PC_W)) i_decoder (
        .inst (inst_q),
        .pc   (pc_q),
        .dec  (if_dec.src)
    );

    decode_check #(.PC_W(PC_W)) i_check (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .flush    (flush),
        .stall    (stall),
        .mem_wait (mem_wait),
        .in_d     (if_dec.dst),
        .out_d    (if_chk.src)
    );

    issue_latch #(.PC_W(PC_W)) i_issue (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .flush    (flush),
        .stall    (stall),
        .mem_wait (mem_wait),
        .in_d     (if_chk.dst),
        .pc       (out_pc),
        .opc      (out_opc),
        .rd       (out_rd),
        .rs1      (out_rs1),
        .rs2      (out_rs2),
        .csr      (out_csr),
        .imm      (out_imm)
    );

endmodule

// ==== decode_front_asserts.sv ====
module decode_front_asserts
    import decode_pkg::*;
#(
    parameter int PC_W = 32
) (
    input logic             CLK,
    input logic             arst_n,
    input logic             flush,
    input logic             stall,
    input logic             mem_wait,
    input logic [IMM_W-1:0] in_imm,
    input logic [PC_W-1:0]  out_pc,
    input logic [OPC_W-1:0] out_opc,
    input logic [REG_W-1:0] out_rd,
    input logic [REG_W-1:0] out_rs1,
    input logic [REG_W-1:0] out_rs2,
    input logic [CSR_W-1:0] out_csr,
    input logic [IMM_W-1:0] out_imm
);

    logic all_zero;

    assign all_zero = (out_pc == '0) && (out_opc == '0) && (out_rd == '0) && (out_rs1 == '0)
                   && (out_rs2 == '0) && (out_csr == '0) && (out_imm == '0);

    a_flush_clears: assert property (@(posedge CLK) disable iff (!arst_n)
        flush |=> all_zero)
        else $error("check stage outputs not zero after a flush");

    a_hold_stable: assert property (@(posedge CLK) disable iff (!arst_n)
        (!flush && (stall || mem_wait))
        |=> $stable({out_pc, out_opc, out_rd, out_rs1, out_rs2, out_csr, out_imm}))
        else $error("check stage outputs changed during a hold");

    // a marked word must leave as a bare JAL.
    a_unimp_hidden: assert property (@(posedge CLK) disable iff (!arst_n)
        (in_imm == UNIMP_IMM && !flush && !stall && !mem_wait)
        |=> (out_imm == '0 && out_opc == {10'b0, OP_JAL}))
        else $error("unimp immediate reached the check stage outputs");

endmodule

bind decode_check decode_front_asserts #(.PC_W(PC_W)) i_asserts (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .flush    (flush),
    .stall    (stall),
    .mem_wait (mem_wait),
    .in_imm   (in_d.imm),
    .out_pc   (out_d.pc),
    .out_opc  (out_d.opc),
    .out_rd   (out_d.rd),
    .out_rs1  (out_d.rs1),
    .out_rs2  (out_d.rs2),
    .out_csr  (out_d.csr),
    .out_imm  (out_d.imm)
);

// ==== tb_decode_front.sv ====
module tb_decode_front
    import decode_pkg::*;
();

    localparam int PC_W = 32;

    typedef struct packed {
        logic [PC_W-1:0]  pc;
        logic [OPC_W-1:0] opc;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;
        logic [CSR_W-1:0] csr;
        logic [IMM_W-1:0] imm;
    } fields_t;

    // legal major opcodes in the order of the stimulus classes.
    localparam logic [6:0] OPS [11] = '{OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH,
        OP_LOAD, OP_STORE, OP_OPIMM, OP_OP, OP_MISCMEM, OP_SYSTEM};

    logic              CLK;
    logic              arst_n;
    logic              flush;
    logic              stall;
    logic              mem_wait;
    logic [INST_W-1:0] inst;
    logic [PC_W-1:0]   pc;
    logic [PC_W-1:0]   out_pc;
    logic [OPC_W-1:0]  out_opc;
    logic [REG_W-1:0]  out_rd;
    logic [REG_W-1:0]  out_rs1;
    logic [REG_W-1:0]  out_rs2;
    logic [CSR_W-1:0]  out_csr;
    logic [IMM_W-1:0]  out_imm;

    logic [INST_W-1:0] s0_inst   = '0;         // fetch stage of the model.
    logic [PC_W-1:0]   s0_pc     = '0;
    fields_t           s1        = '0;         // check stage before the substitution.
    fields_t           s2        = '0;         // issue stage.
    integer            seed      = 32'h7051;
    int                err_count = 0;
    int                err_mark  = 0;
    int                test_fails = 0;
    logic [INST_W-1:0] cur_word  = '0;
    logic [PC_W-1:0]   cur_pc    = '0;
    logic [PC_W-1:0]   pc_next   = 32'h0000_1000;
    logic              held      = 1'b0;
    logic              rst_level = 1'b0;

    decode_front #(.PC_W(PC_W)) i_dut (.*);

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    function automatic int rnd_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // mode 0 is OP and OP-IMM, 1 the immediate formats, 2 illegal words, 3 anything.
    function automatic logic [31:0] gen_word(input int mode);
        logic [31:0] w;
        int          k;
        w = $random(seed);
        case (mode)
            0: k = 7 + rnd_below(2);
            1: k = rnd_below(8);
            2: k = 11 + rnd_below(2);
            default: k = rnd_below(13);
        endcase
        if (mode == 1 && k == 7) k = 10;
        if (k < 11) w[6:0] = OPS[k[3:0]];
        else if (k == 11) w[0] = 1'b0;          // no RV32I opcode ends in anything but 11.
        else w = '0;
        return w;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic fields_t model_decode(input logic [31:0] w, input logic [PC_W-1:0] p);
        fields_t     d;
        logic [12:0] b;
        logic [20:0] j;
        logic [6:0]  f7k;
        d     = '0;
        d.pc  = p;
        d.imm = UNIMP_IMM;
        b     = {w[31], w[7], w[30:25], w[11:8], 1'b0};
        j     = {w[31], w[19:12], w[20], w[30:21], 1'b0};
        f7k   = (w[6:0] == OP_OPIMM && w[13:12] == 2'b01) ? w[31:25] : 7'b0;
        case (w[6:0])
            OP_LUI, OP_AUIPC, OP_JAL: begin
                d.opc = {10'b0, w[6:0]};
                d.rd  = w[11:7];
                d.imm = (w[6:0] == OP_JAL) ? {{11{j[20]}}, j} : {w[31:12], 12'b0};
            end
            OP_JALR, OP_LOAD, OP_MISCMEM, OP_SYSTEM, OP_OPIMM: begin
                d.opc = {f7k, w[14:12], w[6:0]};   // shifts keep funct7.
                d.rd  = w[11:7];
                d.rs1 = w[19:15];
                d.imm = {{20{w[31]}}, w[31:20]};
            end
            OP_BRANCH, OP_STORE: begin
                d.opc = {7'b0, w[14:12], w[6:0]};
                d.rs1 = w[19:15];
                d.rs2 = w[24:20];
                d.imm = (w[6:0] == OP_BRANCH) ? {{19{b[12]}}, b}
                                              : {{20{w[31]}}, w[31:25], w[11:7]};
            end
            OP_OP: begin
                d.opc = {w[31:25], w[14:12], w[6:0]};
                d.rd  = w[11:7];
                d.rs1 = w[19:15];
                d.rs2 = w[24:20];
                d.imm = '0;
            end
            default: ;
        endcase
        return d;
    endfunction

    function automatic fields_t substitute(input fields_t d);
        fields_t r;
        r     = d;
        r.csr = d.imm[CSR_W-1:0];
        if (d.imm == UNIMP_IMM) begin
            r     = '0;
            r.pc  = d.pc;                       // only the pc survives.
            r.opc = {10'b0, OP_JAL};
        end
        return r;
    endfunction

    task automatic model_step();
        if (!arst_n || flush) begin
            s0_inst = '0;
            s0_pc   = '0;
            s1      = '0;
            s2      = '0;
        end else if (!(stall || mem_wait)) begin
            s2      = substitute(s1);
            s1      = model_decode(s0_inst, s0_pc);
            s0_inst = inst;
            s0_pc   = pc;
        end
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR %0t: %s is %h, expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_outputs(input fields_t e);
        check_field("pc", out_pc, e.pc);
        check_field("opc", 32'(out_opc), 32'(e.opc));
        check_field("rd", 32'(out_rd), 32'(e.rd));
        check_field("rs1", 32'(out_rs1), 32'(e.rs1));
        check_field("rs2", 32'(out_rs2), 32'(e.rs2));
        check_field("csr", 32'(out_csr), 32'(e.csr));
        check_field("imm", out_imm, e.imm);
    endtask

    // the model advances on the values the DUT samples at this edge.
    task automatic drive_cycle(input logic [31:0] w, input logic [PC_W-1:0] p,
                               input logic f, input logic s, input logic m);
        @(posedge CLK);
        model_step();
        arst_n   <= rst_level;
        inst     <= w;
        pc       <= p;
        flush    <= f;
        stall    <= s;
        mem_wait <= m;
        @(negedge CLK);
        check_outputs(s2);
    endtask

    task automatic run_random(input int mode, input int n, input int stall_pct,
                              input int wait_pct, input int flush_pct);
        logic s;
        logic m;
        logic f;
        for (int i = 0; i < n; i++) begin
            if (!held) begin                    // a held word is presented again.
                cur_word = gen_word(mode);
                cur_pc   = pc_next;
                pc_next  = pc_next + 4;
            end
            s = (rnd_below(100) < stall_pct);
            m = (rnd_below(100) < wait_pct);
            f = (rnd_below(100) < flush_pct);
            drive_cycle(cur_word, cur_pc, f, s, m);
            held = (s || m) && !f;
        end
    endtask

    task automatic send_marker();
        logic [PC_W-1:0] mark;
        logic            seen;
        mark    = pc_next;
        pc_next = pc_next + 4;
        seen    = 1'b0;
        drive_cycle(gen_word(3), mark, 1'b0, 1'b0, 1'b0);
        for (int i = 0; i < 8 && !seen; i++) begin
            drive_cycle('0, '0, 1'b0, 1'b0, 1'b0);
            seen = (out_pc == mark);
        end
        if (!seen) begin
            $display("timeout: pc %h never reached the issue outputs", mark);
            err_count++;
        end
        held = 1'b0;
    endtask

    task automatic finish_test(input string name);
        if (err_count == err_mark) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: fail, %0d errors", name, err_count - err_mark);
            test_fails++;
        end
        err_mark = err_count;
    endtask

    initial begin
        arst_n   = 1'b0;
        flush    = 1'b0;
        stall    = 1'b0;
        mem_wait = 1'b0;
        inst     = '0;
        pc       = '0;
        for (int i = 0; i < 4; i++) begin
            rst_level = (i >= 2);               // released after the third edge.
            drive_cycle('0, '0, 1'b0, 1'b0, 1'b0);
            check_outputs('0);
        end
        finish_test("reset");
        run_random(0, 40, 0, 0, 0);
        finish_test("legal decode");
        run_random(1, 60, 0, 0, 0);
        finish_test("immediates and csr");
        run_random(2, 30, 0, 0, 0);
        finish_test("unimp substitution");
        run_random(3, 80, 25, 15, 0);
        send_marker();
        finish_test("hold");
        run_random(3, 60, 10, 10, 10);
        send_marker();
        finish_test("flush");
        $display("tests 6, failed %0d, errors %0d", test_fails, err_count);
        if (test_fails == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
decode_pkg.sv
decode_if.sv
fetch_latch.sv
inst_decoder.sv
decode_check.sv
issue_latch.sv
decode_front.sv
decode_front_asserts.sv
tb_decode_front.sv

// ==== Makefile ====
TOP = tb_decode_front

.PHONY: compile run clean

compile:
	verilator --binary --assert -f sources.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
